// File: vectorLoadStore.f
ldstPkg.sv
ringBuffer.sv
ldstDispatch.sv
ldstLane.sv
accessArbiter.sv
commitSequencer.sv
vectorLoadStore.sv
tbClockGen.sv
vectorLoadStoreTb.sv

// File: Bender.yml
package:
  name: vectorLoadStore

sources:
  - ldstPkg.sv
  - ringBuffer.sv
  - ldstDispatch.sv
  - ldstLane.sv
  - accessArbiter.sv
  - commitSequencer.sv
  - vectorLoadStore.sv
  - target: test
    files:
      - tbClockGen.sv
      - vectorLoadStoreTb.sv

// File: vectorLoadStoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module vectorLoadStoreTb;

	localparam int laneCount	= 4;
	localparam int requestDepth	= 4;
	localparam int dataDepth	= 8;
	localparam int tableRows	= 12;
	localparam int burstCount	= laneCount * (requestDepth + 1) + 1;	// Last one must stall

	logic				clock;
	logic				reset;
	logic				cmdValid;
	logic				cmdReady;
	ldstPkg::address_t	cmdBase;
	ldstPkg::address_t	cmdStride;
	ldstPkg::length_t	cmdLength;
	ldstPkg::tag_t		cmdTag;
	logic				memValid;
	logic				memReady;
	ldstPkg::address_t	memAddress;
	ldstPkg::data_t		memRespData;
	logic				outValid;
	logic				outReady;
	ldstPkg::data_t		outData;
	ldstPkg::tag_t		outTag;
	logic				outLast;

	ldstPkg::address_t	tableBase [tableRows];
	ldstPkg::address_t	tableStride [tableRows];
	ldstPkg::length_t	tableLength [tableRows];
	ldstPkg::tag_t		tableTag [tableRows];

	ldstPkg::data_t		expectedData [$];		// Reference queue, one entry per element
	ldstPkg::tag_t		expectedTag [$];
	logic				expectedLast [$];

	logic [31:0]		rngState = 32'haa64_bf57;
	logic				respPending = 1'b0;
	ldstPkg::address_t	respAddress;
	logic				holdOut = 1'b0;			// Forces outReady low
	logic				stallSeen = 1'b0;
	int					cycleCount = 0;
	int					timeoutLimit;

	tbClockGen #(
		.periodNs		(4),
		.resetCycles	(2)
	) u_tbClockGen (
		.clock			(clock),
		.reset			(reset)
	);

	vectorLoadStore #(
		.laneCount		(laneCount),
		.requestDepth	(requestDepth),
		.dataDepth		(dataDepth)
	) u_vectorLoadStore (
		.clock			(clock),
		.reset			(reset),
		.cmdValid		(cmdValid),
		.cmdReady		(cmdReady),
		.cmdBase		(cmdBase),
		.cmdStride		(cmdStride),
		.cmdLength		(cmdLength),
		.cmdTag			(cmdTag),
		.memValid		(memValid),
		.memReady		(memReady),
		.memAddress		(memAddress),
		.memRespData	(memRespData),
		.outValid		(outValid),
		.outReady		(outReady),
		.outData		(outData),
		.outTag			(outTag),
		.outLast		(outLast)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers and checks
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		state = state ^ (state << 13);
		state = state ^ (state >> 17);
		state = state ^ (state << 5);
		return state;
	endfunction

	// Address in the upper half, inverted address in the lower half
	function automatic ldstPkg::data_t memoryWord(input ldstPkg::address_t address);
		return {address, ~address};
	endfunction

	function automatic int totalElements();
		int sum;
		sum = burstCount * 16;		// Burst rows are all full length
		for (int row = 0; row < tableRows; row++) begin
			sum += int'(tableLength[row]) + 1;
		end
		return sum;
	endfunction

	task automatic stopOnError(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkData(input string name, input ldstPkg::data_t actual,
			input ldstPkg::data_t expected);
		if (actual !== expected) begin
			stopOnError($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
				name, actual, expected));
		end
	endtask

	task automatic checkTag(input string name, input ldstPkg::tag_t actual,
			input ldstPkg::tag_t expected);
		if (actual !== expected) begin
			stopOnError($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
				name, actual, expected));
		end
	endtask

	task automatic checkLast(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			stopOnError($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
				name, actual, expected));
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			stopOnError($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
				name, actual, expected));
		end
	endtask

	task automatic setRow(input int row, input ldstPkg::address_t base,
			input ldstPkg::address_t stride, input ldstPkg::length_t length,
			input ldstPkg::tag_t tag);
		tableBase[row]		= base;
		tableStride[row]	= stride;
		tableLength[row]	= length;
		tableTag[row]		= tag;
	endtask

	// Element i reads base + i * stride, last flag on element length only
	task automatic pushExpected(input ldstPkg::address_t base, input ldstPkg::address_t stride,
			input ldstPkg::length_t length, input ldstPkg::tag_t tag);
		ldstPkg::address_t address;
		for (int i = 0; i <= int'(length); i++) begin
			address = base + ldstPkg::address_t'(i * int'(stride));
			expectedData.push_back(memoryWord(address));
			expectedTag.push_back(tag);
			expectedLast.push_back(i == int'(length));
		end
	endtask

	task automatic sendCommand(input ldstPkg::address_t base, input ldstPkg::address_t stride,
			input ldstPkg::length_t length, input ldstPkg::tag_t tag);
		int waitCycles;
		waitCycles	= 0;
		cmdValid	= 1'b1;
		cmdBase		= base;
		cmdStride	= stride;
		cmdLength	= length;
		cmdTag		= tag;
		while (cmdReady !== 1'b1) begin
			waitCycles++;
			if (holdOut && waitCycles >= 8) begin		// Queues full, let the output drain
				stallSeen	= 1'b1;
				holdOut		<= 1'b0;
			end
			@(negedge clock);
		end
		pushExpected(base, stride, length, tag);		// Accepted at the coming rising edge
		@(negedge clock);
		cmdValid = 1'b0;
	endtask

	task automatic waitDrained();
		while (expectedData.size() != 0) begin
			@(negedge clock);
		end
	endtask

	task automatic checkElement();
		if (expectedData.size() == 0) begin
			stopOnError("The output delivered an element with no command left to match it");
		end else begin
			checkData("outData", outData, expectedData.pop_front());
			checkTag("outTag", outTag, expectedTag.pop_front());
			checkLast("outLast", outLast, expectedLast.pop_front());
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory model, ready generation and output monitor
	////////////////////////////////////////////////////////////////////////////

	// memValid and memAddress do not depend on memReady, so the read
	// that the next rising edge accepts is known here
	always @(negedge clock) begin
		memRespData	= respPending ? memoryWord(respAddress) : '0;
		rngState	= xorshift(rngState);
		memReady	= rngState[3] | rngState[7];				// About three in four
		outReady	= ~holdOut & (rngState[11] | rngState[19]);
		respPending	= (memValid === 1'b1) && memReady;
		respAddress	= memAddress;
		if (outValid === 1'b1 && outReady) begin
			checkElement();
		end
	end

	always @(posedge clock) begin
		if (!reset) begin
			cycleCount <= cycleCount + 1;
			if (cycleCount >= timeoutLimit) begin
				stopOnError("Timeout: the output stream stalled before all elements arrived");
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		cmdValid	= 1'b0;
		cmdBase		= '0;
		cmdStride	= '0;
		cmdLength	= '0;
		cmdTag		= '0;
		memReady	= 1'b0;
		memRespData	= '0;
		outReady	= 1'b0;
		setRow(0, 16'h0100, 16'h0001, 4'd7, 4'h1);		// Plain stride 1
		setRow(1, 16'h0200, 16'h0000, 4'd3, 4'h2);		// Same word repeated
		setRow(2, 16'h1000, 16'h0400, 4'd5, 4'h3);
		setRow(3, 16'hfff0, 16'h0005, 4'd9, 4'h4);		// Wraps past the top
		setRow(4, 16'h0300, 16'h0001, 4'd0, 4'h5);
		setRow(5, 16'h8000, 16'hc000, 4'd15, 4'h6);
		setRow(6, 16'h0040, 16'h0002, 4'd1, 4'h7);
		setRow(7, 16'habcd, 16'hffff, 4'd11, 4'h8);		// Walks downward
		setRow(8, 16'h0000, 16'h0003, 4'd15, 4'h9);
		setRow(9, 16'h7ffe, 16'h0001, 4'd2, 4'ha);
		setRow(10, 16'h1234, 16'h0100, 4'd0, 4'hb);
		setRow(11, 16'hf000, 16'h1111, 4'd6, 4'hc);
		timeoutLimit = 40 * totalElements() + 100;

		@(negedge clock);
		wait (reset === 1'b0);
		@(negedge clock);
		repeat (5) begin		// Idle state before any command
			checkFlag("cmdReady", cmdReady, 1'b1);
			checkFlag("memValid", memValid, 1'b0);
			checkFlag("outValid", outValid, 1'b0);
			@(negedge clock);
		end

		sendCommand(tableBase[0], tableStride[0], tableLength[0], tableTag[0]);
		waitDrained();
		for (int row = 1; row < tableRows; row++) begin
			sendCommand(tableBase[row], tableStride[row], tableLength[row], tableTag[row]);
		end
		waitDrained();

		// Full length commands with the output blocked fill every request queue
		holdOut <= 1'b1;
		for (int k = 0; k < burstCount; k++) begin
			sendCommand(tableBase[k % tableRows], tableStride[k % tableRows], 4'hf,
				tableTag[k % tableRows]);
		end
		holdOut <= 1'b0;
		if (!stallSeen) begin
			stopOnError("cmdReady never dropped while the output was held off");
		end
		waitDrained();

		repeat (10) begin		// Unit idle, no late duplicates or stray reads
			@(negedge clock);
			checkFlag("outValid", outValid, 1'b0);
			checkFlag("memValid", memValid, 1'b0);
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
	parameter int periodNs		= 4,
	parameter int resetCycles	= 2
)(
	output	logic	clock,
	output	logic	reset
);

	initial begin
		clock = 1'b0;
		forever #(periodNs / 2.0) clock = ~clock;
	end

	// Released on a falling edge, like every other input
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: vectorLoadStore.sv
`timescale 1ns/1ps
`default_nettype none

module vectorLoadStore #(
	parameter int laneCount		= 4,
	parameter int requestDepth	= 4,
	parameter int dataDepth		= 8
)(
	input	logic				clock,
	input	logic				reset,
	input	logic				cmdValid,
	output	logic				cmdReady,
	input	ldstPkg::address_t	cmdBase,
	input	ldstPkg::address_t	cmdStride,
	input	ldstPkg::length_t	cmdLength,
	input	ldstPkg::tag_t		cmdTag,
	output	logic				memValid,
	input	logic				memReady,
	output	ldstPkg::address_t	memAddress,
	input	ldstPkg::data_t		memRespData,
	output	logic				outValid,
	input	logic				outReady,
	output	ldstPkg::data_t		outData,
	output	ldstPkg::tag_t		outTag,
	output	logic				outLast
);

	logic [laneCount-1:0]				laneCmdValid;
	logic [laneCount-1:0]				laneCmdReady;
	logic [laneCount-1:0]				laneReadValid;
	ldstPkg::address_t [laneCount-1:0]	laneReadAddress;
	logic [laneCount-1:0]				laneReadGrant;
	logic [laneCount-1:0]				laneRespValid;
	ldstPkg::data_t						respData;			// Shared by all lanes
	logic [laneCount-1:0]				laneElementValid;
	logic [laneCount-1:0]				laneElementReady;
	ldstPkg::data_t [laneCount-1:0]		laneElementData;
	ldstPkg::tag_t [laneCount-1:0]		laneElementTag;
	logic [laneCount-1:0]				laneElementLast;

	ldstDispatch #(
		.laneCount		(laneCount)
	) u_ldstDispatch (
		.clock			(clock),
		.reset			(reset),
		.cmdValid		(cmdValid),
		.cmdReady		(cmdReady),
		.laneCmdValid	(laneCmdValid),
		.laneCmdReady	(laneCmdReady)
	);

	////////////////////////////////////////////////////////////////////////////
	// Load lanes
	////////////////////////////////////////////////////////////////////////////

	// Command payload fans out to all lanes, valid picks one
	for (genvar laneIndex = 0; laneIndex < laneCount; laneIndex++) begin : gLane
		ldstLane #(
			.requestDepth	(requestDepth),
			.dataDepth		(dataDepth)
		) u_ldstLane (
			.clock			(clock),
			.reset			(reset),
			.cmdValid		(laneCmdValid[laneIndex]),
			.cmdReady		(laneCmdReady[laneIndex]),
			.cmdBase		(cmdBase),
			.cmdStride		(cmdStride),
			.cmdLength		(cmdLength),
			.cmdTag			(cmdTag),
			.readValid		(laneReadValid[laneIndex]),
			.readAddress	(laneReadAddress[laneIndex]),
			.readGrant		(laneReadGrant[laneIndex]),
			.respValid		(laneRespValid[laneIndex]),
			.respData		(respData),
			.elementValid	(laneElementValid[laneIndex]),
			.elementReady	(laneElementReady[laneIndex]),
			.elementData	(laneElementData[laneIndex]),
			.elementTag		(laneElementTag[laneIndex]),
			.elementLast	(laneElementLast[laneIndex])
		);
	end

	accessArbiter #(
		.laneCount		(laneCount)
	) u_accessArbiter (
		.clock			(clock),
		.reset			(reset),
		.readValid		(laneReadValid),
		.readAddress	(laneReadAddress),
		.readGrant		(laneReadGrant),
		.memValid		(memValid),
		.memReady		(memReady),
		.memAddress		(memAddress),
		.memRespData	(memRespData),
		.respValid		(laneRespValid),
		.respData		(respData)
	);

	commitSequencer #(
		.laneCount		(laneCount)
	) u_commitSequencer (
		.clock			(clock),
		.reset			(reset),
		.elementValid	(laneElementValid),
		.elementReady	(laneElementReady),
		.elementData	(laneElementData),
		.elementTag		(laneElementTag),
		.elementLast	(laneElementLast),
		.outValid		(outValid),
		.outReady		(outReady),
		.outData		(outData),
		.outTag			(outTag),
		.outLast		(outLast)
	);

endmodule

`default_nettype wire

// File: commitSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module commitSequencer #(
	parameter int laneCount	= 4
)(
	input	logic								clock,
	input	logic								reset,
	input	logic [laneCount-1:0]				elementValid,
	output	logic [laneCount-1:0]				elementReady,
	input	ldstPkg::data_t [laneCount-1:0]		elementData,
	input	ldstPkg::tag_t [laneCount-1:0]		elementTag,
	input	logic [laneCount-1:0]				elementLast,
	output	logic								outValid,
	input	logic								outReady,
	output	ldstPkg::data_t						outData,
	output	ldstPkg::tag_t						outTag,
	output	logic								outLast
);

	localparam int indexWidth = $clog2(laneCount);

	logic [indexWidth-1:0]	commitPointer;		// Lane holding the oldest command

	////////////////////////////////////////////////////////////////////////////
	// Head lane select
	////////////////////////////////////////////////////////////////////////////

	assign outValid	= elementValid[commitPointer];
	assign outData	= elementData[commitPointer];
	assign outTag	= elementTag[commitPointer];
	assign outLast	= elementLast[commitPointer];

	// Other lanes keep their words until their turn
	always_comb begin
		elementReady				= '0;
		elementReady[commitPointer]	= outReady;
	end

	// Follows the dispatch rotation one command at a time
	always_ff @(posedge clock) begin
		if (reset) begin
			commitPointer <= '0;
		end else if (outValid && outReady && outLast) begin
			if (commitPointer == indexWidth'(laneCount - 1)) begin
				commitPointer <= '0;
			end else begin
				commitPointer <= commitPointer + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: accessArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module accessArbiter #(
	parameter int laneCount	= 4
)(
	input	logic								clock,
	input	logic								reset,
	input	logic [laneCount-1:0]				readValid,
	input	ldstPkg::address_t [laneCount-1:0]	readAddress,
	output	logic [laneCount-1:0]				readGrant,		// High on acceptance only
	output	logic								memValid,
	input	logic								memReady,
	output	ldstPkg::address_t					memAddress,
	input	ldstPkg::data_t						memRespData,	// One cycle after acceptance
	output	logic [laneCount-1:0]				respValid,
	output	ldstPkg::data_t						respData
);

	localparam int indexWidth = $clog2(laneCount);

	logic [indexWidth-1:0]	priorityPointer;	// First lane to consider
	logic [indexWidth-1:0]	grantIndex;
	logic					accepted;
	logic					respPending;
	logic [indexWidth-1:0]	respLane;			// Owner of the word now returning

	// Search from the priority pointer for the first requesting lane
	always_comb begin
		int candidate;
		logic found;
		found		= 1'b0;
		grantIndex	= priorityPointer;
		for (int offset = 0; offset < laneCount; offset++) begin
			candidate = (int'(priorityPointer) + offset) % laneCount;
			if (!found && readValid[candidate]) begin
				found		= 1'b1;
				grantIndex	= candidate[indexWidth-1:0];
			end
		end
	end

	assign memValid		= |readValid;
	assign memAddress	= readAddress[grantIndex];
	assign accepted		= memValid & memReady;
	assign readGrant	= accepted ? (laneCount'(1) << grantIndex) : '0;
	assign respValid	= respPending ? (laneCount'(1) << respLane) : '0;
	assign respData		= memRespData;

	always_ff @(posedge clock) begin
		if (reset) begin
			priorityPointer	<= '0;
			respPending		<= 1'b0;
			respLane		<= '0;
		end else begin
			respPending <= accepted;
			if (accepted) begin
				respLane <= grantIndex;
				if (grantIndex == indexWidth'(laneCount - 1)) begin		// Winner goes last
					priorityPointer <= '0;
				end else begin
					priorityPointer <= grantIndex + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: ldstLane.sv
`timescale 1ns/1ps
`default_nettype none

module ldstLane #(
	parameter int requestDepth	= 4,
	parameter int dataDepth		= 8
)(
	input	logic				clock,
	input	logic				reset,
	input	logic				cmdValid,
	output	logic				cmdReady,
	input	ldstPkg::address_t	cmdBase,
	input	ldstPkg::address_t	cmdStride,
	input	ldstPkg::length_t	cmdLength,
	input	ldstPkg::tag_t		cmdTag,
	output	logic				readValid,		// To arbiter
	output	ldstPkg::address_t	readAddress,
	input	logic				readGrant,		// Read accepted this cycle
	input	logic				respValid,		// Word for this lane
	input	ldstPkg::data_t		respData,
	output	logic				elementValid,	// To commit sequencer
	input	logic				elementReady,
	output	ldstPkg::data_t		elementData,
	output	ldstPkg::tag_t		elementTag,
	output	logic				elementLast
);

	localparam int requestWidth	= 2 * ldstPkg::addressWidth + ldstPkg::lengthWidth
		+ ldstPkg::tagWidth;
	localparam int entryWidth	= ldstPkg::dataWidth + ldstPkg::tagWidth + 1;
	localparam int countWidth	= $clog2(dataDepth + 1);
	localparam logic [countWidth:0] creditLimit = (countWidth + 1)'(dataDepth);

	logic [requestWidth-1:0]	requestHead;
	logic						requestFull;
	logic						requestEmpty;
	logic						requestPop;
	ldstPkg::address_t			headBase;
	ldstPkg::address_t			headStride;
	ldstPkg::length_t			headLength;
	ldstPkg::tag_t				headTag;

	logic						busy;			// Walker owns a command
	ldstPkg::address_t			walkAddress;
	ldstPkg::address_t			walkStride;
	ldstPkg::length_t			remaining;		// Reads left minus one
	ldstPkg::tag_t				walkTag;
	ldstPkg::tag_t				pendingTag;		// Goes with next response
	logic						pendingLast;

	logic [countWidth-1:0]		dataCount;
	logic [countWidth-1:0]		inFlight;
	logic [countWidth:0]		reserved;
	logic						dataEmpty;

	////////////////////////////////////////////////////////////////////////////
	// Request queue
	////////////////////////////////////////////////////////////////////////////

	assign cmdReady		= ~requestFull;
	assign requestPop	= ~busy & ~requestEmpty;
	assign {headBase, headStride, headLength, headTag} = requestHead;

	ringBuffer #(
		.entryCount	(requestDepth),
		.entryWidth	(requestWidth)
	) u_requestQueue (
		.clock		(clock),
		.reset		(reset),
		.write		(cmdValid & cmdReady),
		.writeData	({cmdBase, cmdStride, cmdLength, cmdTag}),
		.read		(requestPop),
		.readData	(requestHead),
		.full		(requestFull),
		.empty		(requestEmpty),
		.count		()
	);

	////////////////////////////////////////////////////////////////////////////
	// Address walker
	////////////////////////////////////////////////////////////////////////////

	// Space in the data buffer is reserved for every read in flight
	assign reserved		= dataCount + inFlight;
	assign readValid	= busy & (reserved < creditLimit);
	assign readAddress	= walkAddress;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (requestPop) begin
			busy <= 1'b1;
		end else if (readGrant && remaining == '0) begin
			busy <= 1'b0;		// Last read of the command
		end
	end

	always_ff @(posedge clock) begin
		if (requestPop) begin
			walkAddress	<= headBase;
			walkStride	<= headStride;
			remaining	<= headLength;
			walkTag		<= headTag;
		end else if (readGrant) begin
			walkAddress	<= walkAddress + walkStride;	// Wraps modulo 2^16
			remaining	<= remaining - 1'b1;
		end
		if (readGrant) begin
			pendingTag	<= walkTag;
			pendingLast	<= (remaining == '0);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			inFlight <= '0;
		end else begin
			case ({readGrant, respValid})
				2'b10:		inFlight <= inFlight + 1'b1;
				2'b01:		inFlight <= inFlight - 1'b1;
				default:	inFlight <= inFlight;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Data buffer
	////////////////////////////////////////////////////////////////////////////

	assign elementValid = ~dataEmpty;

	ringBuffer #(
		.entryCount	(dataDepth),
		.entryWidth	(entryWidth)
	) u_dataBuffer (
		.clock		(clock),
		.reset		(reset),
		.write		(respValid),
		.writeData	({respData, pendingTag, pendingLast}),
		.read		(elementValid & elementReady),
		.readData	({elementData, elementTag, elementLast}),
		.full		(),
		.empty		(dataEmpty),
		.count		(dataCount)
	);

endmodule

`default_nettype wire

// File: ldstDispatch.sv
`timescale 1ns/1ps
`default_nettype none

module ldstDispatch #(
	parameter int laneCount	= 4
)(
	input	logic					clock,
	input	logic					reset,
	input	logic					cmdValid,		// From outside
	output	logic					cmdReady,
	output	logic [laneCount-1:0]	laneCmdValid,	// One-hot, target lane only
	input	logic [laneCount-1:0]	laneCmdReady
);

	localparam int indexWidth = $clog2(laneCount);

	logic [indexWidth-1:0]	rotation;		// Lane that takes the next command
	logic					accepted;

	////////////////////////////////////////////////////////////////////////////
	// Target lane decode
	////////////////////////////////////////////////////////////////////////////

	// Only the lane under the pointer may stall the command port
	assign cmdReady	= laneCmdReady[rotation];
	assign accepted	= cmdValid & cmdReady;

	always_comb begin
		laneCmdValid			= '0;
		laneCmdValid[rotation]	= cmdValid;
	end

	////////////////////////////////////////////////////////////////////////////
	// Rotation pointer
	////////////////////////////////////////////////////////////////////////////

	// Command k always lands in lane k mod laneCount
	always_ff @(posedge clock) begin
		if (reset) begin
			rotation <= '0;
		end else if (accepted) begin
			if (rotation == indexWidth'(laneCount - 1)) begin
				rotation <= '0;
			end else begin
				rotation <= rotation + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: ringBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module ringBuffer #(
	parameter int entryCount	= 4,
	parameter int entryWidth	= 8
)(
	input	logic								clock,
	input	logic								reset,
	input	logic								write,		// Push writeData
	input	logic [entryWidth-1:0]				writeData,
	input	logic								read,		// Pop head entry
	output	logic [entryWidth-1:0]				readData,	// Head entry
	output	logic								full,
	output	logic								empty,
	output	logic [$clog2(entryCount+1)-1:0]	count		// Occupancy
);

	localparam int pointerWidth	= (entryCount > 1) ? $clog2(entryCount) : 1;
	localparam int countWidth	= $clog2(entryCount + 1);

	logic [entryWidth-1:0]		storage [entryCount];
	logic [pointerWidth-1:0]	writePointer;
	logic [pointerWidth-1:0]	readPointer;
	logic						doWrite;
	logic						doRead;

	// Wraps at entryCount, which need not be a power of two
	function automatic logic [pointerWidth-1:0] nextPointer(
		input logic [pointerWidth-1:0] pointer
	);
		if (pointer == pointerWidth'(entryCount - 1)) begin
			return '0;
		end
		return pointer + 1'b1;
	endfunction

	assign doWrite	= write & ~full;		// Overflowing write is ignored
	assign doRead	= read & ~empty;
	assign full		= (count == countWidth'(entryCount));
	assign empty	= (count == '0);
	assign readData	= storage[readPointer];

	always_ff @(posedge clock) begin
		if (doWrite) begin
			storage[writePointer] <= writeData;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			writePointer	<= '0;
			readPointer		<= '0;
			count			<= '0;
		end else begin
			if (doWrite) begin
				writePointer <= nextPointer(writePointer);
			end
			if (doRead) begin
				readPointer <= nextPointer(readPointer);
			end
			case ({doWrite, doRead})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;		// Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: ldstPkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Widths shared by the load unit and its testbench
////////////////////////////////////////////////////////////////////////////

package ldstPkg;

	localparam int addressWidth	= 16;		// Word address, wraps modulo 2^16
	localparam int dataWidth	= 32;		// One memory word
	localparam int lengthWidth	= 4;		// Element count minus one
	localparam int tagWidth		= 4;		// Command identifier

	////////////////////////////////////////////////////////////////////////////
	// Field types
	////////////////////////////////////////////////////////////////////////////

	// Memory word address
	typedef logic [addressWidth-1:0]	address_t;

	// Memory word
	typedef logic [dataWidth-1:0]		data_t;

	// Zero means one element, all ones means sixteen
	typedef logic [lengthWidth-1:0]		length_t;

	// Tag travels with every returned element
	typedef logic [tagWidth-1:0]		tag_t;

endpackage

`default_nettype wire
